// File: hdl/board_macros.svh
/*
  Board-wide widths, GPIO bit positions and boot constants
  GPIO field positions must agree with the firmware's register map
  Debounce count assumes the 100 MHz system clock (1 ms per key)
*/

`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

//----------------------------------------
// Word widths
//----------------------------------------
`define XLEN                    32
`define NUM_OF_GPIOS            32

// Five-way navigation keys and DIP switches
`define NUM_KEYS                5
`define NUM_SWITCHES            8

//----------------------------------------
// Boot and key timing
//----------------------------------------
`define DEFAULT_START_ADDR      32'h8000_0000
`define DEFAULT_DEBOUNCE_CYCLES 100000

//----------------------------------------
// GPIO input word fields
//----------------------------------------
`define GPIO_KEY_LSB            0
`define GPIO_SW_LSB             8

// GPIO output word fields
`define GPIO_SEG_LSB            0
`define GPIO_DIG_LSB            8
`define GPIO_RGB1_LSB           16
`define GPIO_RGB2_LSB           20
`define GPIO_LED_LSB            24

`endif

// File: hdl/board_io_pkg.sv
/*
  Types for the board pins and the MCU GPIO words
  Keys arrive active low; segment lines leave active low
*/

`include "board_macros.svh"

package board_io_pkg;

    //----------------------------------------
    // MCU side
    //----------------------------------------

    // One GPIO word, in or out
    typedef logic [`NUM_OF_GPIOS - 1 : 0] gpio_word_t;

    //----------------------------------------
    // Board inputs
    //----------------------------------------
    typedef logic [`NUM_KEYS - 1 : 0]     key_vec_t;
    typedef logic [`NUM_SWITCHES - 1 : 0] sw_vec_t;

    //----------------------------------------
    // Board outputs
    //----------------------------------------

    // Segments A..G in bits 0..6, DP in bit 7
    typedef logic [7 : 0]                 seg_vec_t;
    // Digit enables, index 0 is the rightmost digit
    typedef logic [3 : 0]                 dig_vec_t;
    // Red, green, blue from bit 0 up
    typedef logic [2 : 0]                 rgb_t;
    typedef logic [7 : 0]                 led_vec_t;

endpackage : board_io_pkg

// File: hdl/boot_pkg.sv
/*
  Types shared by the boot sequencer and the hardware loader
  Addresses are byte addresses of one CPU word width
*/

`include "board_macros.svh"

package boot_pkg;

    //----------------------------------------
    // CPU start address
    //----------------------------------------

    // Same width as the CPU word
    typedef logic [`XLEN - 1 : 0] cpu_addr_t;

endpackage : boot_pkg

// File: hdl/key_debouncer.sv
/*
  One-key debouncer, raw key in, clean level out
  Output is 1 (released) after reset
  Glitches shorter than debounce_cycles never reach the output
*/

`timescale 1ns/1ns
`default_nettype none

module key_debouncer #(
    parameter int unsigned debounce_cycles = 100000
) (
    input  wire  clk_100MHz,
    input  wire  pll_locked,
    input  wire  data_in,
    output logic data_out
);

    // Wide enough to hold debounce_cycles itself
    localparam int unsigned cnt_width = $clog2(debounce_cycles + 1);

    logic [1 : 0]             sync_ff;
    logic [cnt_width - 1 : 0] stable_cnt;

    //----------------------------------------
    // Synchronizer, two flops
    //----------------------------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            sync_ff <= 2'b11;
        end else begin
            sync_ff <= {sync_ff[0], data_in};
        end
    end

    //----------------------------------------
    // Stability counter
    //----------------------------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            stable_cnt <= '0;
            data_out   <= 1'b1;
        end else if (sync_ff[1] != data_out) begin
            // Flip on the last of debounce_cycles differing cycles
            if (stable_cnt == cnt_width'(debounce_cycles - 1)) begin
                stable_cnt <= '0;
                data_out   <= sync_ff[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end else begin
            // Any agreement restarts the count
            stable_cnt <= '0;
        end
    end

endmodule : key_debouncer

`default_nettype wire

// File: hdl/key_input_block.sv
/*
  Debounces the five navigation keys and builds the GPIO input word
  Switches pass through raw; firmware filters them if it needs to
  key_int is a level, high while any key is held
*/

`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module key_input_block #(
    parameter int unsigned debounce_cycles = `DEFAULT_DEBOUNCE_CYCLES
) (
    input  wire                        clk_100MHz,
    input  wire                        pll_locked,
    input  board_io_pkg::key_vec_t     keys,
    input  board_io_pkg::sw_vec_t      switches,
    output board_io_pkg::gpio_word_t   gpio_in,
    output logic                       key_int
);

    // Debounced keys, still active low
    board_io_pkg::key_vec_t keys_db;

    //----------------------------------------
    // One debouncer per key
    //----------------------------------------
    for (genvar i = 0; i < `NUM_KEYS; i++) begin : gen_keys
        key_debouncer #(
            .debounce_cycles (debounce_cycles)
        ) u_key_debouncer (
            .clk_100MHz (clk_100MHz),
            .pll_locked (pll_locked),
            .data_in    (keys[i]),
            .data_out   (keys_db[i])
        );
    end

    //----------------------------------------
    // GPIO input word
    //----------------------------------------
    always_comb begin
        // Unused bits read as zero
        gpio_in = '0;
        // Pressed key reads as 1
        gpio_in[`GPIO_KEY_LSB +: `NUM_KEYS]    = ~keys_db;
        gpio_in[`GPIO_SW_LSB  +: `NUM_SWITCHES] = switches;
    end

    // Interrupt while any key is down
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            key_int <= 1'b0;
        end else begin
            key_int <= ~(&keys_db);
        end
    end

endmodule : key_input_block

`default_nettype wire

// File: hdl/loader_link.sv
/*
  Boot start sequencing and the link to the hardware loader
  One start pulse follows reset; every loader strobe restarts the CPU
  mcu_reset_n is combinational and also covers PLL lock loss
*/

`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module loader_link (
    input  wire                 clk_100MHz,
    input  wire                 pll_locked,
    input  wire                 loader_cpu_start,
    input  boot_pkg::cpu_addr_t loader_cpu_start_addr,
    input  wire                 loader_cpu_reset,
    input  wire                 loader_tx_sel,
    input  wire                 loader_txd,
    input  wire                 cpu_txd,
    output logic                mcu_start,
    output boot_pkg::cpu_addr_t mcu_start_addr,
    output logic                mcu_reset_n,
    output logic                txd
);

    // Fills with ones from bit 0 after reset
    logic [1 : 0] boot_sr;

    //----------------------------------------
    // Boot start and restart
    //----------------------------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            boot_sr        <= 2'b00;
            mcu_start      <= 1'b0;
            mcu_start_addr <= `DEFAULT_START_ADDR;
        end else begin
            boot_sr   <= {boot_sr[0], 1'b1};
            // Pulse once on the 01 pattern, or on a loader strobe
            mcu_start <= loader_cpu_start | (boot_sr[0] & ~boot_sr[1]);
            if (loader_cpu_start) begin
                mcu_start_addr <= loader_cpu_start_addr;
            end else if (!boot_sr[1]) begin
                // Default address until boot completes
                mcu_start_addr <= `DEFAULT_START_ADDR;
            end
        end
    end

    // CPU held in reset on loader request
    assign mcu_reset_n = ~loader_cpu_reset & pll_locked;

    //----------------------------------------
    // TXD source select, registered
    //----------------------------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            txd <= 1'b0;
        end else begin
            txd <= loader_tx_sel ? loader_txd : cpu_txd;
        end
    end

endmodule : loader_link

`default_nettype wire

// File: hdl/step_board_top.sv
/*
  Board glue around the MCU on the Cyclone 10 board
  Clock and pll_locked come from the PLL outside this block
  Display outputs are combinational from the GPIO output word
*/

`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module step_board_top #(
    parameter int unsigned debounce_cycles = `DEFAULT_DEBOUNCE_CYCLES
) (
    input  wire                      clk_100MHz,
    input  wire                      pll_locked,
    // Board inputs
    input  board_io_pkg::key_vec_t   keys,
    input  board_io_pkg::sw_vec_t    switches,
    input  wire                      accel_int,
    // MCU side
    input  board_io_pkg::gpio_word_t gpio_out,
    output board_io_pkg::gpio_word_t gpio_in,
    output logic [1 : 0]             mcu_int,
    output logic                     mcu_start,
    output boot_pkg::cpu_addr_t      mcu_start_addr,
    output logic                     mcu_reset_n,
    // Hardware loader
    input  wire                      loader_cpu_start,
    input  boot_pkg::cpu_addr_t      loader_cpu_start_addr,
    input  wire                      loader_cpu_reset,
    input  wire                      loader_tx_sel,
    input  wire                      loader_txd,
    input  wire                      cpu_txd,
    output logic                     txd,
    // Display pins
    output board_io_pkg::led_vec_t   led,
    output board_io_pkg::seg_vec_t   seg_n,
    output board_io_pkg::dig_vec_t   dig,
    output board_io_pkg::rgb_t       rgb1,
    output board_io_pkg::rgb_t       rgb2
);

    logic key_int;

    //----------------------------------------
    // Keys and switches
    //----------------------------------------
    key_input_block #(
        .debounce_cycles (debounce_cycles)
    ) u_key_input_block (
        .clk_100MHz (clk_100MHz),
        .pll_locked (pll_locked),
        .keys       (keys),
        .switches   (switches),
        .gpio_in    (gpio_in),
        .key_int    (key_int)
    );

    // Accelerometer on INT1, keys on INT0
    assign mcu_int = {accel_int, key_int};

    //----------------------------------------
    // Boot and loader link
    //----------------------------------------
    loader_link u_loader_link (
        .clk_100MHz            (clk_100MHz),
        .pll_locked            (pll_locked),
        .loader_cpu_start      (loader_cpu_start),
        .loader_cpu_start_addr (loader_cpu_start_addr),
        .loader_cpu_reset      (loader_cpu_reset),
        .loader_tx_sel         (loader_tx_sel),
        .loader_txd            (loader_txd),
        .cpu_txd               (cpu_txd),
        .mcu_start             (mcu_start),
        .mcu_start_addr        (mcu_start_addr),
        .mcu_reset_n           (mcu_reset_n),
        .txd                   (txd)
    );

    //----------------------------------------
    // GPIO output mapping
    //----------------------------------------

    // Segment lines are active low on the board
    assign seg_n = ~gpio_out[`GPIO_SEG_LSB +: $bits(board_io_pkg::seg_vec_t)];
    // dig[0] drives digit 4, dig[3] digit 1
    assign dig   = gpio_out[`GPIO_DIG_LSB +: $bits(board_io_pkg::dig_vec_t)];
    assign rgb1  = gpio_out[`GPIO_RGB1_LSB +: $bits(board_io_pkg::rgb_t)];
    assign rgb2  = gpio_out[`GPIO_RGB2_LSB +: $bits(board_io_pkg::rgb_t)];
    assign led   = gpio_out[`GPIO_LED_LSB +: $bits(board_io_pkg::led_vec_t)];

endmodule : step_board_top

`default_nettype wire

// File: test/clock_gen.sv
/*
  Testbench clock and reset source
  10 ns clock, pll_locked low for the first 5 cycles
  Reset is released on a falling edge, away from the sampling edge
*/

`timescale 1ns/1ns

module clock_gen (
    output logic clk_100MHz,
    output logic pll_locked
);

    // 100 MHz free-running clock
    initial begin
        clk_100MHz = 1'b0;
        forever #5 clk_100MHz = ~clk_100MHz;
    end

    // PLL lock after 5 cycles
    initial begin
        pll_locked = 1'b0;
        repeat (5) @(posedge clk_100MHz);
        @(negedge clk_100MHz);
        pll_locked = 1'b1;
    end

endmodule : clock_gen

// File: test/step_board_properties.sv
/*
  Concurrent checks on the board glue, attached to the top by bind
  Expected values come from the pin map and the boot timing rules
  fail_count is read by the testbench for its per-test results
*/

`timescale 1ns/1ns

`include "board_macros.svh"

module step_board_properties (
    input wire                      clk_100MHz,
    input wire                      pll_locked,
    input board_io_pkg::sw_vec_t    switches,
    input wire                      accel_int,
    input board_io_pkg::gpio_word_t gpio_out,
    input board_io_pkg::gpio_word_t gpio_in,
    input wire [1 : 0]              mcu_int,
    input wire                      mcu_start,
    input boot_pkg::cpu_addr_t      mcu_start_addr,
    input wire                      mcu_reset_n,
    input wire                      loader_cpu_start,
    input boot_pkg::cpu_addr_t      loader_cpu_start_addr,
    input wire                      loader_cpu_reset,
    input wire                      loader_tx_sel,
    input wire                      loader_txd,
    input wire                      cpu_txd,
    input wire                      txd,
    input board_io_pkg::led_vec_t   led,
    input board_io_pkg::seg_vec_t   seg_n,
    input board_io_pkg::dig_vec_t   dig,
    input board_io_pkg::rgb_t       rgb1,
    input board_io_pkg::rgb_t       rgb2
);

    int unsigned  fail_count = 0;
    // Rising edges since reset release, saturates at 3
    logic [1 : 0] edge_cnt;

    // Loader strobe and address of the previous cycle
    logic                strobe_d;
    boot_pkg::cpu_addr_t strobe_addr_d;
    boot_pkg::cpu_addr_t addr_exp;

    // Upper GPIO input bits 31..5
    logic [26 : 0]       gpio_hi_got;
    logic [26 : 0]       gpio_hi_exp;

    // Display pins, led down to seg_n
    logic [25 : 0]       disp_got;
    logic [25 : 0]       disp_exp;

    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            edge_cnt      <= 2'd0;
            strobe_d      <= 1'b0;
            strobe_addr_d <= '0;
        end else begin
            if (edge_cnt != 2'd3) begin
                edge_cnt <= edge_cnt + 2'd1;
            end
            strobe_d      <= loader_cpu_start;
            strobe_addr_d <= loader_cpu_start_addr;
        end
    end

    // Strobed address wins, default address on the boot pulse
    assign addr_exp = strobe_d ? strobe_addr_d : boot_pkg::cpu_addr_t'(`DEFAULT_START_ADDR);

    // Switches in 15..8, zeros in 31..16 and 7..5
    assign gpio_hi_got = gpio_in[31 : 5];
    assign gpio_hi_exp = {16'h0000, switches, 3'b000};

    // Bit map of the output word
    assign disp_got = {led, rgb2, rgb1, dig, seg_n};
    assign disp_exp = {gpio_out[31 : 24], gpio_out[22 : 20], gpio_out[18 : 16],
                       gpio_out[11 : 8], ~gpio_out[7 : 0]};

    //----------------------------------------
    // Boot and loader
    //----------------------------------------

    // One boot pulse after the second edge, plus one per strobe
    a_start : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        mcu_start == (strobe_d || (edge_cnt == 2'd2)))
        else begin
            fail_count++;
            $error("[ERROR] %0t mcu_start got %b exp %b",
                   $time, $sampled(mcu_start), !$sampled(mcu_start));
        end

    a_start_addr : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        mcu_start |-> mcu_start_addr == addr_exp)
        else begin
            fail_count++;
            $error("[ERROR] %0t mcu_start_addr got %h exp %h",
                   $time, $sampled(mcu_start_addr), $sampled(addr_exp));
        end

    a_reset_n : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        mcu_reset_n == !loader_cpu_reset)
        else begin
            fail_count++;
            $error("[ERROR] %0t mcu_reset_n got %b exp %b",
                   $time, $sampled(mcu_reset_n), !$sampled(mcu_reset_n));
        end

    // TXD one cycle behind the selected source
    a_txd : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        txd == ($past(loader_tx_sel) ? $past(loader_txd) : $past(cpu_txd)))
        else begin
            fail_count++;
            $error("[ERROR] %0t txd got %b exp %b",
                   $time, $sampled(txd), !$sampled(txd));
        end

    //----------------------------------------
    // GPIO input word and interrupts
    //----------------------------------------
    a_gpio_in : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        gpio_hi_got == gpio_hi_exp)
        else begin
            fail_count++;
            $error("[ERROR] %0t gpio_in[31:5] got %h exp %h",
                   $time, $sampled(gpio_hi_got), $sampled(gpio_hi_exp));
        end

    a_accel_int : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        mcu_int[1] == accel_int)
        else begin
            fail_count++;
            $error("[ERROR] %0t mcu_int[1] got %b exp %b",
                   $time, $sampled(mcu_int[1]), !$sampled(mcu_int[1]));
        end

    // Key interrupt one cycle after any pressed key
    a_key_int : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        mcu_int[0] == (|$past(gpio_in[`GPIO_KEY_LSB +: `NUM_KEYS])))
        else begin
            fail_count++;
            $error("[ERROR] %0t mcu_int[0] got %b exp %b",
                   $time, $sampled(mcu_int[0]), !$sampled(mcu_int[0]));
        end

    //----------------------------------------
    // Display pins, same cycle
    //----------------------------------------
    a_display : assert property (@(posedge clk_100MHz) disable iff (!pll_locked)
        disp_got == disp_exp)
        else begin
            fail_count++;
            $error("[ERROR] %0t {led,rgb2,rgb1,dig,seg_n} got %h exp %h",
                   $time, $sampled(disp_got), $sampled(disp_exp));
        end

endmodule : step_board_properties

// File: test/step_board_tb.sv
/*
  Top-level testbench for the board glue
  Short debounce count of 8 cycles keeps key tests fast
  Most checks live in the bound property module
*/

`timescale 1ns/1ns

`include "board_macros.svh"

module step_board_tb;

    localparam int unsigned deb = 8;
    // Summed test lengths in cycles, plus reset and margin
    localparam int unsigned test_cycles = 10 + 8 * 6 + 20 + 5 * (22 + deb + 6)
                                        + (deb + 12) + 30 + 30 + 40;
    localparam int unsigned margin_cycles = 200;

    logic                      clk_100MHz;
    logic                      pll_locked;
    board_io_pkg::key_vec_t    keys = '1;
    board_io_pkg::sw_vec_t     switches = '0;
    logic                      accel_int = 1'b0;
    board_io_pkg::gpio_word_t  gpio_out = '0;
    logic                      loader_cpu_start = 1'b0;
    boot_pkg::cpu_addr_t       loader_cpu_start_addr = '0;
    logic                      loader_cpu_reset = 1'b0;
    logic                      loader_tx_sel = 1'b0;
    logic                      loader_txd = 1'b0;
    logic                      cpu_txd = 1'b0;
    board_io_pkg::gpio_word_t  gpio_in;
    logic [1 : 0]              mcu_int;
    logic                      mcu_start;
    boot_pkg::cpu_addr_t       mcu_start_addr;
    logic                      mcu_reset_n;
    logic                      txd;
    board_io_pkg::led_vec_t    led;
    board_io_pkg::seg_vec_t    seg_n;
    board_io_pkg::dig_vec_t    dig;
    board_io_pkg::rgb_t        rgb1;
    board_io_pkg::rgb_t        rgb2;

    int unsigned tb_errors = 0;
    int unsigned tests_passed = 0;
    int unsigned tests_failed = 0;
    logic [31 : 0] rnd = 32'd4958;

    clock_gen u_clock_gen (
        .clk_100MHz (clk_100MHz),
        .pll_locked (pll_locked)
    );

    step_board_top #(
        .debounce_cycles (deb)
    ) u_step_board_top (.*);

    bind step_board_top step_board_properties u_props (.*);

    // xorshift32 step
    function automatic logic [31 : 0] xorshift32(input logic [31 : 0] x);
        logic [31 : 0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned error_total();
        return tb_errors + u_step_board_top.u_props.fail_count;
    endfunction

    task automatic close_test(input string name, input int unsigned errs_before);
        if (error_total() == errs_before) begin
            tests_passed++;
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s, %0d errors", name, error_total() - errs_before);
        end
    endtask

    //----------------------------------------
    // Key tests
    //----------------------------------------
    task automatic press_key(input int k);
        int unsigned n;
        logic        seen;
        seen = 1'b0;
        @(posedge clk_100MHz);
        keys[k] <= 1'b0;
        for (n = 1; n <= deb + 4; n++) begin
            @(negedge clk_100MHz);
            if (gpio_in[k] && mcu_int[0]) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            tb_errors++;
            $display("Key %0d press did not reach gpio_in and mcu_int[0] in time", k);
        end
        // Hold the key for at least 20 cycles in all
        repeat (21 - n) @(posedge clk_100MHz);
        keys[k] <= 1'b1;
        repeat (deb + 6) @(negedge clk_100MHz);
        if (gpio_in[k] || mcu_int[0]) begin
            tb_errors++;
            $display("[ERROR] %0t gpio_in[%0d]/mcu_int[0] got %b/%b exp 0/0",
                     $time, k, gpio_in[k], mcu_int[0]);
        end
    endtask

    // Four-cycle glitch must be filtered out
    task automatic glitch_key();
        int unsigned i;
        @(posedge clk_100MHz);
        keys[0] <= 1'b0;
        for (i = 0; i < deb + 12; i++) begin
            @(posedge clk_100MHz);
            if (i == 3) begin
                keys[0] <= 1'b1;
            end
            @(negedge clk_100MHz);
            if (gpio_in[4 : 0] !== 5'b00000 || mcu_int[0] !== 1'b0) begin
                tb_errors++;
                $display("[ERROR] %0t gpio_in[4:0]/mcu_int[0] got %b/%b exp 00000/0",
                         $time, gpio_in[4 : 0], mcu_int[0]);
            end
        end
    endtask

    //----------------------------------------
    // Watchdog
    //----------------------------------------
    initial begin
        #((test_cycles + margin_cycles) * 10);
        $display("Timeout, tests did not finish in %0d cycles", test_cycles + margin_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    //----------------------------------------
    // Test sequence
    //----------------------------------------
    initial begin
        int unsigned errs;
        @(posedge pll_locked);

        // Boot pulse is checked by the properties
        errs = error_total();
        repeat (10) @(posedge clk_100MHz);
        close_test("boot start", errs);

        errs = error_total();
        for (int i = 0; i < 8; i++) begin
            rnd = xorshift32(rnd);
            @(posedge clk_100MHz);
            loader_cpu_start      <= 1'b1;
            loader_cpu_start_addr <= rnd;
            loader_cpu_reset      <= rnd[3];
            @(posedge clk_100MHz);
            loader_cpu_start <= 1'b0;
            repeat (4) @(posedge clk_100MHz);
            loader_cpu_reset <= rnd[9];
        end
        @(posedge clk_100MHz);
        loader_cpu_reset <= 1'b0;
        close_test("loader restart and reset", errs);

        errs = error_total();
        for (int k = 0; k < `NUM_KEYS; k++) begin
            rnd = xorshift32(rnd);
            @(posedge clk_100MHz);
            switches  <= rnd[7 : 0];
            accel_int <= rnd[8];
            press_key(k);
        end
        glitch_key();
        close_test("key debounce and interrupt", errs);

        errs = error_total();
        repeat (30) begin
            rnd = xorshift32(rnd);
            @(posedge clk_100MHz);
            switches  <= rnd[15 : 8];
            accel_int <= rnd[0];
        end
        close_test("gpio input word", errs);

        errs = error_total();
        repeat (30) begin
            rnd = xorshift32(rnd);
            @(posedge clk_100MHz);
            gpio_out <= rnd;
        end
        close_test("display mapping", errs);

        errs = error_total();
        repeat (40) begin
            rnd = xorshift32(rnd);
            @(posedge clk_100MHz);
            loader_tx_sel <= rnd[4];
            loader_txd    <= rnd[11];
            cpu_txd       <= rnd[22];
        end
        repeat (2) @(posedge clk_100MHz);
        close_test("transmit select", errs);

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_total());
        if (error_total() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : step_board_tb

// File: step_board.f
+incdir+hdl
hdl/board_io_pkg.sv
hdl/boot_pkg.sv
hdl/key_debouncer.sv
hdl/key_input_block.sv
hdl/loader_link.sv
hdl/step_board_top.sv
test/clock_gen.sv
test/step_board_properties.sv
test/step_board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f step_board.f \
    --top-module step_board_tb -o sim_step_board > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_step_board +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
! grep -q "Simulation FAILED" sim.log && grep -q "Simulation PASSED" sim.log \
    && { echo "Run passed"; exit 0; } \
    || { echo "Run failed"; exit 1; }
